// File: all.f
+incdir+common
common/oisc_pkg.sv
decode/rv_decoder.sv
subleq/microcode_rom.sv
subleq/subleq_engine.sv
logic/reg_bank.sv
logic/instr_sequencer.sv
logic/wb_oisc.sv
tests/wb_oisc_assert.sv
tests/tb_wb_oisc.sv

// File: common/oisc_defs.svh
`ifndef OISC_DEFS_SVH
`define OISC_DEFS_SVH

`define XLEN        32
`define RADDR_W     6
`define UPC_W       8
`define UOP_W       16
`define UROM_DEPTH  64
`define RESET_PC    32'h0000_0000
`define UJUMP_DONE  8'hFF            // Jump code that ends a routine

// Scratch registers, low half of the bank
`define REG_TMP0    6'd0
`define REG_RVPC    6'd1
`define REG_SRC1    6'd2
`define REG_SRC2    6'd3
`define REG_IMMI    6'd4
`define REG_ONE     6'd5
`define REG_NEXT    6'd6
`define REG_TMP1    6'd7

// RISC-V registers sit in the upper half
`define RV_REG(IDX) {1'b1, IDX}
`define REG_X0      `RV_REG(5'd0)

// Microroutine entry points
`define UENTRY_ADD  8'd0
`define UENTRY_SUB  8'd6
`define UENTRY_ADDI 8'd8
`define UENTRY_SW   8'd12
`define UENTRY_NOP  8'd16

`endif

// File: common/oisc_pkg.sv
`default_nettype none

`include "oisc_defs.svh"

package oisc_pkg;

   typedef logic [`XLEN-1:0]    word_t;
   typedef logic [`RADDR_W-1:0] raddr_t;
   typedef logic [`UPC_W-1:0]   upc_t;

   // Micro-word, b = b - a then branch on result <= 0
   typedef struct packed {
      logic [(`UOP_W-`UPC_W)/2-1:0] a;
      logic [(`UOP_W-`UPC_W)/2-1:0] b;
      logic signed [`UPC_W-1:0]     jump;
   } uop_t;

   typedef enum logic [6:0] {
      FETCH_PC    = 7'b000_0001,
      FETCH_INSTR = 7'b000_0010,
      PLACE_SRC1  = 7'b000_0100,
      PLACE_SRC2  = 7'b000_1000,
      PLACE_IMM   = 7'b001_0000,
      EXECUTE     = 7'b010_0000,
      STORE       = 7'b100_0000
   } rv_state_e;

   typedef enum logic [2:0] {
      UFETCH = 3'b001,
      UEXEC  = 3'b010,
      UWB    = 3'b100
   } micro_state_e;

   typedef struct packed {
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [4:0] rd;
      word_t      imm;
      upc_t       uentry;
      logic       is_store;
      logic       is_rtype;
   } decoded_t;

endpackage

`default_nettype wire

// File: decode/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module rv_decoder (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire oisc_pkg::word_t    instr_i,
   input  wire                     load_i,
   output oisc_pkg::decoded_t      dec_o
);
   import oisc_pkg::*;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   word_t      instr_q;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr_q[6:0];
   assign funct3 = instr_q[14:12];
   assign funct7 = instr_q[31:25];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_q <= '0;                              // Decodes as unsupported
      end else if (load_i) begin
         instr_q <= instr_i;
      end
   end

   always_comb begin
      dec_o.rs1      = instr_q[19:15];
      dec_o.rs2      = instr_q[24:20];
      dec_o.rd       = instr_q[11:7];
      dec_o.imm      = {{20{instr_q[31]}}, instr_q[31:20]};   // I-type
      dec_o.uentry   = `UENTRY_NOP;
      dec_o.is_store = 1'b0;
      dec_o.is_rtype = 1'b0;
      case (opcode)
         OPC_OP: begin
            if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
               dec_o.uentry   = `UENTRY_ADD;
               dec_o.is_rtype = 1'b1;
            end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               dec_o.uentry   = `UENTRY_SUB;
               dec_o.is_rtype = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin
               dec_o.uentry = `UENTRY_ADDI;
            end
         end
         OPC_STORE: begin
            if (funct3 == 3'b010) begin
               dec_o.uentry   = `UENTRY_SW;
               dec_o.is_store = 1'b1;
               dec_o.imm      = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            end
         end
         default: ;
      endcase
      // Unsupported opcodes only advance the PC and never write rd
      if (dec_o.uentry == `UENTRY_NOP) begin
         dec_o.rd = '0;
      end
   end

endmodule

`default_nettype wire

// File: logic/instr_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module instr_sequencer (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire oisc_pkg::decoded_t dec_i,
   input  wire oisc_pkg::word_t    rdata_a_i,
   input  wire oisc_pkg::raddr_t   eng_ra_i,
   input  wire oisc_pkg::raddr_t   eng_rb_i,
   input  wire oisc_pkg::raddr_t   eng_wa_i,
   input  wire oisc_pkg::word_t    eng_wdata_i,
   input  wire                     eng_we_i,
   input  wire                     eng_done_i,
   input  wire oisc_pkg::word_t    eng_result_i,
   input  wire                     wb_ack_i,
   output oisc_pkg::raddr_t        bank_ra_o,
   output oisc_pkg::raddr_t        bank_rb_o,
   output oisc_pkg::raddr_t        bank_wa_o,
   output oisc_pkg::word_t         bank_wdata_o,
   output logic                    bank_we_o,
   output logic                    load_o,
   output logic                    start_o,
   output logic                    wb_cyc_o,
   output logic                    wb_stb_o,
   output logic                    wb_we_o,
   output logic [3:0]              wb_sel_o,
   output oisc_pkg::word_t         wb_adr_o,
   output oisc_pkg::word_t         wb_dat_o
);
   import oisc_pkg::*;

   rv_state_e state;
   rv_state_e nxt;

   // -------------------------------------------------------------------------
   // Instruction FSM
   always_comb begin
      nxt = state;
      case (state)
         FETCH_PC:    nxt = FETCH_INSTR;
         FETCH_INSTR: if (wb_ack_i) nxt = PLACE_SRC1;
         PLACE_SRC1:  nxt = PLACE_SRC2;
         PLACE_SRC2:  nxt = dec_i.is_rtype ? EXECUTE : PLACE_IMM;   // R-type skips IMMI
         PLACE_IMM:   nxt = EXECUTE;
         EXECUTE:     if (eng_done_i) nxt = dec_i.is_store ? STORE : FETCH_PC;
         STORE:       if (wb_ack_i) nxt = FETCH_PC;
         default:     nxt = FETCH_PC;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= FETCH_PC;
         start_o <= 1'b0;
      end else begin
         state   <= nxt;
         start_o <= (nxt == EXECUTE) && (state != EXECUTE);   // First EXECUTE cycle
      end
   end

   always_ff @(posedge clk) begin
      if (state == FETCH_PC) begin
         wb_adr_o <= rdata_a_i;                      // Current PC
      end else if (state == EXECUTE && eng_done_i && dec_i.is_store) begin
         wb_adr_o <= eng_result_i;                   // SW address from routine
      end
      if (state == PLACE_SRC2 && dec_i.is_store) begin
         wb_dat_o <= rdata_a_i;                      // rs2 is the store data
      end
   end

   // -------------------------------------------------------------------------
   // Bank port steering
   always_comb begin
      bank_ra_o    = `REG_RVPC;
      bank_rb_o    = `REG_X0;
      bank_wa_o    = `REG_TMP0;
      bank_wdata_o = rdata_a_i;
      bank_we_o    = 1'b0;
      case (state)
         PLACE_SRC1: begin
            bank_ra_o = `RV_REG(dec_i.rs1);
            bank_wa_o = `REG_SRC1;
            bank_we_o = 1'b1;
         end
         PLACE_SRC2: begin
            bank_ra_o = `RV_REG(dec_i.rs2);
            bank_wa_o = `REG_SRC2;
            bank_we_o = 1'b1;
         end
         PLACE_IMM: begin
            bank_wa_o    = `REG_IMMI;
            bank_wdata_o = dec_i.imm;
            bank_we_o    = 1'b1;
         end
         EXECUTE: begin
            bank_ra_o    = eng_ra_i;
            bank_rb_o    = eng_rb_i;
            bank_wa_o    = eng_wa_i;
            bank_wdata_o = eng_wdata_i;
            bank_we_o    = eng_we_i;
            if (eng_done_i) begin                     // Engine idle, rd writeback
               bank_wa_o    = `RV_REG(dec_i.rd);
               bank_wdata_o = eng_result_i;
               bank_we_o    = (dec_i.rd != 5'd0) && !dec_i.is_store;
            end
         end
         default: ;
      endcase
   end

   // -------------------------------------------------------------------------
   // Wishbone master
   assign load_o   = (state == FETCH_INSTR) && wb_ack_i;
   assign wb_stb_o = (state == FETCH_INSTR) || (state == STORE);
   assign wb_cyc_o = wb_stb_o;
   assign wb_we_o  = (state == STORE);
   assign wb_sel_o = 4'hF;                           // Word accesses only

endmodule

`default_nettype wire

// File: logic/reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module reg_bank (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire oisc_pkg::raddr_t ra_i,
   input  wire oisc_pkg::raddr_t rb_i,
   input  wire oisc_pkg::raddr_t wa_i,
   input  wire oisc_pkg::word_t  wdata_i,
   input  wire                   we_i,
   output oisc_pkg::word_t       rdata_a_o,
   output oisc_pkg::word_t       rdata_b_o
);
   import oisc_pkg::*;

   localparam int DEPTH = 1 << `RADDR_W;

   word_t regs [DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
         regs[`REG_ONE]  <= word_t'(1);
         regs[`REG_NEXT] <= word_t'(-4);             // PC step, subtracted
         regs[`REG_RVPC] <= `RESET_PC;
      end else if (we_i) begin
         regs[wa_i] <= wdata_i;
      end
   end

   // x0 always reads as zero
   assign rdata_a_o = (ra_i == `REG_X0) ? '0 : regs[ra_i];
   assign rdata_b_o = (rb_i == `REG_X0) ? '0 : regs[rb_i];

endmodule

`default_nettype wire

// File: logic/wb_oisc.sv
`timescale 1ns/10ps
`default_nettype none

module wb_oisc (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  wb_ack_i,
   input  wire oisc_pkg::word_t wb_dat_i,
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic [3:0]           wb_sel_o,
   output logic                 wb_we_o,
   output oisc_pkg::word_t      wb_dat_o,
   output oisc_pkg::word_t      wb_adr_o
);
   import oisc_pkg::*;

   decoded_t dec;
   logic     load;
   logic     start;

   // Engine side of the bank
   raddr_t   eng_ra;
   raddr_t   eng_rb;
   raddr_t   eng_wa;
   word_t    eng_wdata;
   logic     eng_we;
   logic     eng_done;
   word_t    eng_result;

   // Bank ports after the sequencer mux
   raddr_t   bank_ra;
   raddr_t   bank_rb;
   raddr_t   bank_wa;
   word_t    bank_wdata;
   logic     bank_we;
   word_t    rdata_a;
   word_t    rdata_b;

   rv_decoder u_decoder (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr_i (wb_dat_i),
      .load_i  (load),
      .dec_o   (dec)
   );

   subleq_engine u_engine (
      .clk       (clk),
      .rst_n     (rst_n),
      .start_i   (start),
      .entry_i   (dec.uentry),
      .rdata_a_i (rdata_a),
      .rdata_b_i (rdata_b),
      .ra_o      (eng_ra),
      .rb_o      (eng_rb),
      .wa_o      (eng_wa),
      .wdata_o   (eng_wdata),
      .we_o      (eng_we),
      .done_o    (eng_done),
      .result_o  (eng_result)
   );

   reg_bank u_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .ra_i      (bank_ra),
      .rb_i      (bank_rb),
      .wa_i      (bank_wa),
      .wdata_i   (bank_wdata),
      .we_i      (bank_we),
      .rdata_a_o (rdata_a),
      .rdata_b_o (rdata_b)
   );

   instr_sequencer u_seq (
      .clk          (clk),
      .rst_n        (rst_n),
      .dec_i        (dec),
      .rdata_a_i    (rdata_a),
      .eng_ra_i     (eng_ra),
      .eng_rb_i     (eng_rb),
      .eng_wa_i     (eng_wa),
      .eng_wdata_i  (eng_wdata),
      .eng_we_i     (eng_we),
      .eng_done_i   (eng_done),
      .eng_result_i (eng_result),
      .wb_ack_i     (wb_ack_i),
      .bank_ra_o    (bank_ra),
      .bank_rb_o    (bank_rb),
      .bank_wa_o    (bank_wa),
      .bank_wdata_o (bank_wdata),
      .bank_we_o    (bank_we),
      .load_o       (load),
      .start_o      (start),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o),
      .wb_we_o      (wb_we_o),
      .wb_sel_o     (wb_sel_o),
      .wb_adr_o     (wb_adr_o),
      .wb_dat_o     (wb_dat_o)
   );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_wb_oisc -f all.f

out=$(./obj_dir/Vtb_wb_oisc)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
   exit 0
else
   exit 1
fi

// File: subleq/microcode_rom.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module microcode_rom (
   input  wire oisc_pkg::upc_t upc_i,
   output oisc_pkg::uop_t      uop_o
);
   import oisc_pkg::*;

   localparam logic [7:0] STEP = 8'd1;              // Fall through either way

   function automatic uop_t uw(input raddr_t a, input raddr_t b, input logic [7:0] jump);
      uw = {a[3:0], b[3:0], jump};
   endfunction

   always_comb begin
      uop_o = uw(`REG_TMP0, `REG_TMP0, `UJUMP_DONE); // Unused words end the routine
      if (upc_i < `UROM_DEPTH) begin
         case (upc_i)
            // ADD computes -(-SRC1 - SRC2) through TMP0
            `UENTRY_ADD + 8'd0:  uop_o = uw(`REG_NEXT, `REG_RVPC, STEP);
            `UENTRY_ADD + 8'd1:  uop_o = uw(`REG_TMP0, `REG_TMP0, STEP);
            `UENTRY_ADD + 8'd2:  uop_o = uw(`REG_SRC1, `REG_TMP0, STEP);
            `UENTRY_ADD + 8'd3:  uop_o = uw(`REG_SRC2, `REG_TMP0, STEP);
            `UENTRY_ADD + 8'd4:  uop_o = uw(`REG_TMP1, `REG_TMP1, STEP);
            `UENTRY_ADD + 8'd5:  uop_o = uw(`REG_TMP0, `REG_TMP1, `UJUMP_DONE);
            // SUB
            `UENTRY_SUB + 8'd0:  uop_o = uw(`REG_NEXT, `REG_RVPC, STEP);
            `UENTRY_SUB + 8'd1:  uop_o = uw(`REG_SRC2, `REG_SRC1, `UJUMP_DONE);
            // ADDI
            `UENTRY_ADDI + 8'd0: uop_o = uw(`REG_NEXT, `REG_RVPC, STEP);
            `UENTRY_ADDI + 8'd1: uop_o = uw(`REG_TMP0, `REG_TMP0, STEP);
            `UENTRY_ADDI + 8'd2: uop_o = uw(`REG_IMMI, `REG_TMP0, STEP);
            `UENTRY_ADDI + 8'd3: uop_o = uw(`REG_TMP0, `REG_SRC1, `UJUMP_DONE);
            // SW leaves the store address as the last result
            `UENTRY_SW + 8'd0:   uop_o = uw(`REG_NEXT, `REG_RVPC, STEP);
            `UENTRY_SW + 8'd1:   uop_o = uw(`REG_TMP1, `REG_TMP1, STEP);
            `UENTRY_SW + 8'd2:   uop_o = uw(`REG_IMMI, `REG_TMP1, STEP);
            `UENTRY_SW + 8'd3:   uop_o = uw(`REG_TMP1, `REG_SRC1, `UJUMP_DONE);
            // Unsupported opcode
            `UENTRY_NOP:         uop_o = uw(`REG_NEXT, `REG_RVPC, `UJUMP_DONE);
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: subleq/subleq_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module subleq_engine (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  start_i,
   input  wire oisc_pkg::upc_t  entry_i,
   input  wire oisc_pkg::word_t rdata_a_i,
   input  wire oisc_pkg::word_t rdata_b_i,
   output oisc_pkg::raddr_t     ra_o,
   output oisc_pkg::raddr_t     rb_o,
   output oisc_pkg::raddr_t     wa_o,
   output oisc_pkg::word_t      wdata_o,
   output logic                 we_o,
   output logic                 done_o,
   output oisc_pkg::word_t      result_o
);
   import oisc_pkg::*;

   micro_state_e ustate;
   logic         busy;
   upc_t         upc;
   uop_t         rom_word;
   uop_t         uop_q;
   word_t        op_a;
   word_t        op_b;
   word_t        diff;
   logic         finish;

   microcode_rom u_rom (
      .upc_i (upc),
      .uop_o (rom_word)
   );

   assign diff    = op_b - op_a;
   assign finish  = busy && (ustate == UWB) && (uop_q.jump == `UJUMP_DONE);

   assign ra_o    = raddr_t'(uop_q.a);
   assign rb_o    = raddr_t'(uop_q.b);
   assign wa_o    = raddr_t'(uop_q.b);               // Result goes back to b
   assign wdata_o = diff;
   assign we_o    = busy && (ustate == UWB);

   // -------------------------------------------------------------------------
   // Micro-sequencer, three cycles per micro-word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         ustate <= UFETCH;
         upc    <= '0;
         uop_q  <= '0;
         done_o <= 1'b0;
      end else begin
         done_o <= finish;
         if (start_i) begin
            busy   <= 1'b1;
            upc    <= entry_i;
            ustate <= UFETCH;
         end else if (busy) begin
            case (ustate)
               UFETCH: begin
                  uop_q  <= rom_word;
                  ustate <= UEXEC;
               end
               UEXEC: ustate <= UWB;
               UWB: begin
                  ustate <= UFETCH;
                  if (finish) begin
                     busy <= 1'b0;                    // Back to idle
                  end else if ($signed(diff) <= 0) begin
                     upc <= upc + upc_t'(uop_q.jump);
                  end else begin
                     upc <= upc + upc_t'(1);
                  end
               end
               default: ustate <= UFETCH;
            endcase
         end
      end
   end

   // Operand latches and the result handed back with done
   always_ff @(posedge clk) begin
      if (busy && ustate == UEXEC) begin
         op_a <= rdata_a_i;
         op_b <= rdata_b_i;
      end
      if (finish) begin
         result_o <= diff;
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_wb_oisc.sv
`timescale 1ns/10ps
`default_nettype none

`include "oisc_defs.svh"

module tb_wb_oisc;
   import oisc_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int PROG_LEN    = 21;
   localparam int MAX_ACC     = 64;
   localparam int CYC_PER_INS = 50;                  // Worst case with 5 wait states
   localparam int TIMEOUT_NS  = 2 * (PROG_LEN + 1) * CYC_PER_INS * CLK_PERIOD
                                + 20 * CLK_PERIOD;

   typedef struct packed {
      logic  we;
      word_t adr;
      word_t dat;
   } bus_acc_t;

   logic       clk        = 1'b0;
   logic       rst_n      = 1'b1;                    // Pulsed low on the first edge
   logic       ack        = 1'b0;
   word_t      rdata      = '0;
   logic       cyc;
   logic       stb;
   logic       we;
   logic [3:0] sel;
   word_t      wdata;
   word_t      adr;

   word_t      prog [PROG_LEN];
   bus_acc_t   exp_acc [MAX_ACC];
   int         exp_cnt    = 0;
   int         acc_idx    = 0;
   bus_acc_t   stores_imm [$];
   bus_acc_t   stores_rnd [$];
   logic       random_ack = 1'b0;
   int         wait_cnt   = 0;
   int         ack_delay  = 0;
   integer     seed       = 32'hc23e94a9;
   int         checks     = 0;
   int         errors     = 0;

   wb_oisc dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_ack_i (ack),
      .wb_dat_i (rdata),
      .wb_cyc_o (cyc),
      .wb_stb_o (stb),
      .wb_sel_o (sel),
      .wb_we_o  (we),
      .wb_dat_o (wdata),
      .wb_adr_o (adr)
   );

   bind wb_oisc wb_oisc_assert u_assert (
      .clk   (clk),
      .rst_n (rst_n),
      .stb_i (wb_stb_o),
      .cyc_i (wb_cyc_o),
      .we_i  (wb_we_o),
      .ack_i (wb_ack_i),
      .adr_i (wb_adr_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // -------------------------------------------------------------------------
   // RV32I encoders and program memory contents
   function automatic word_t enc_op(input logic [6:0] f7, input logic [4:0] rd,
                                    input logic [4:0] rs1, input logic [4:0] rs2);
      enc_op = {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   function automatic word_t enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
      enc_addi = {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic word_t enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                    input logic [11:0] imm);
      enc_sw = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // Unused words hold unsupported opcodes that vary with the address
   function automatic word_t fill_word(input word_t addr);
      fill_word = {addr[24:0] ^ addr[31:7], 7'h7F};
   endfunction

   function automatic word_t fetch_word(input word_t addr);
      word_t idx;
      idx = addr >> 2;
      if (addr[1:0] == 2'b00 && idx < word_t'(PROG_LEN)) begin
         fetch_word = prog[idx];
      end else begin
         fetch_word = fill_word(addr);
      end
   endfunction

   task automatic load_program();
      prog[0]  = enc_addi(5'd3, 5'd0, 12'h400);      // Store base
      prog[1]  = enc_addi(5'd1, 5'd0, 12'h7FF);
      prog[2]  = enc_addi(5'd1, 5'd1, 12'h7FF);
      prog[3]  = enc_addi(5'd1, 5'd1, 12'(-1));
      prog[4]  = enc_sw(5'd1, 5'd3, 12'd0);
      prog[5]  = enc_addi(5'd2, 5'd0, 12'(-1));
      prog[6]  = enc_addi(5'd2, 5'd2, 12'd5);        // Wraps to 4
      prog[7]  = enc_sw(5'd2, 5'd3, 12'(-8));
      prog[8]  = enc_addi(5'd4, 5'd0, 12'(-100));
      prog[9]  = enc_addi(5'd5, 5'd0, 12'd37);
      prog[10] = enc_op(7'b0000000, 5'd6, 5'd4, 5'd5);
      prog[11] = enc_op(7'b0100000, 5'd7, 5'd5, 5'd4);
      prog[12] = enc_op(7'b0100000, 5'd8, 5'd4, 5'd5);
      prog[13] = enc_sw(5'd6, 5'd3, 12'd4);
      prog[14] = enc_sw(5'd7, 5'd3, 12'd8);
      prog[15] = enc_sw(5'd8, 5'd3, 12'(-2048));     // Most negative offset
      prog[16] = enc_addi(5'd0, 5'd0, 12'd123);
      prog[17] = enc_op(7'b0000000, 5'd0, 5'd5, 5'd5);
      prog[18] = enc_sw(5'd0, 5'd3, 12'd12);
      prog[19] = enc_op(7'b0000000, 5'd9, 5'd8, 5'd4);
      prog[20] = enc_sw(5'd9, 5'd3, 12'd16);
   endtask

   // -------------------------------------------------------------------------
   // Reference model, runs the program and lists every bus access
   function automatic int predict_accesses();
      word_t      xreg [32];
      word_t      pc;
      word_t      ins;
      word_t      res;
      word_t      imm_i;
      word_t      imm_s;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic       wr;
      int         n;
      for (int i = 0; i < 32; i++) begin
         xreg[i] = '0;
      end
      pc = `RESET_PC;
      n  = 0;
      for (int k = 0; k < PROG_LEN; k++) begin
         ins        = fetch_word(pc);
         exp_acc[n] = '{we: 1'b0, adr: pc, dat: ins};
         n++;
         rd    = ins[11:7];
         rs1   = ins[19:15];
         rs2   = ins[24:20];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         wr    = 1'b0;
         res   = '0;
         if (ins[6:0] == 7'b0110011 && ins[14:12] == 3'b000) begin
            if (ins[31:25] == 7'b0000000) begin
               res = xreg[rs1] + xreg[rs2];
               wr  = 1'b1;
            end else if (ins[31:25] == 7'b0100000) begin
               res = xreg[rs1] - xreg[rs2];
               wr  = 1'b1;
            end
         end else if (ins[6:0] == 7'b0010011 && ins[14:12] == 3'b000) begin
            res = xreg[rs1] + imm_i;
            wr  = 1'b1;
         end else if (ins[6:0] == 7'b0100011 && ins[14:12] == 3'b010) begin
            exp_acc[n] = '{we: 1'b1, adr: xreg[rs1] + imm_s, dat: xreg[rs2]};
            n++;
         end
         if (wr && rd != 5'd0) begin
            xreg[rd] = res;                          // x0 stays zero
         end
         pc = pc + 32'd4;
      end
      exp_acc[n] = '{we: 1'b0, adr: pc, dat: fetch_word(pc)};   // Fetch that ends the run
      n++;
      return n;
   endfunction

   // -------------------------------------------------------------------------
   // Program memory slave
   always @(posedge clk) begin
      if (!rst_n) begin
         ack       <= 1'b0;
         wait_cnt  <= 0;
         ack_delay <= 0;
      end else if (ack) begin
         ack <= 1'b0;                                // One cycle per request
      end else if (stb) begin
         if (wait_cnt >= ack_delay) begin
            ack      <= 1'b1;
            rdata    <= we ? '0 : fetch_word(adr);
            wait_cnt <= 0;
            if (random_ack) begin
               ack_delay <= int'($unsigned($random(seed)) % 6);
            end else begin
               ack_delay <= 0;
            end
         end else begin
            wait_cnt <= wait_cnt + 1;
         end
      end
   end

   task automatic report_mismatch(input string name, input word_t got, input word_t want);
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
   endtask

   // Each completed transfer against the model
   always @(negedge clk) begin
      bus_acc_t want;
      if (!rst_n) begin
         acc_idx = 0;
      end else if (stb && ack && acc_idx < exp_cnt) begin
         want = exp_acc[acc_idx];
         checks++;
         if (we !== want.we) begin
            report_mismatch("wb_we_o", word_t'(we), word_t'(want.we));
         end
         if (adr !== want.adr) begin
            report_mismatch("wb_adr_o", adr, want.adr);
         end
         if (sel !== 4'hF) begin
            report_mismatch("wb_sel_o", word_t'(sel), 32'hF);
         end
         if (want.we) begin
            if (wdata !== want.dat) begin
               report_mismatch("wb_dat_o", wdata, want.dat);
            end
            if (random_ack) begin
               stores_rnd.push_back('{we: we, adr: adr, dat: wdata});
            end else begin
               stores_imm.push_back('{we: we, adr: adr, dat: wdata});
            end
         end
         acc_idx++;
      end
   end

   // -------------------------------------------------------------------------
   // Run control
   task automatic run_program(input logic rand_wait);
      @(posedge clk);
      rst_n      <= 1'b0;
      random_ack <= rand_wait;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      while (acc_idx < exp_cnt) begin
         @(posedge clk);
      end
   endtask

   task automatic compare_store_runs();
      if (stores_rnd.size() != stores_imm.size()) begin
         errors++;
         $display("Store count differs between runs: %0d with wait states, %0d without",
                  stores_rnd.size(), stores_imm.size());
      end else begin
         foreach (stores_imm[k]) begin
            checks++;
            if (stores_rnd[k] !== stores_imm[k]) begin
               errors++;
               $display("Error at %0t ns: store %0d adr/dat = %h/%h, expected %h/%h",
                        $time, k, stores_rnd[k].adr, stores_rnd[k].dat,
                        stores_imm[k].adr, stores_imm[k].dat);
            end
         end
      end
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, dut.u_assert.fail_cnt);
      if (errors == 0 && dut.u_assert.fail_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   initial begin
      load_program();
      exp_cnt = predict_accesses();
      run_program(1'b0);                             // Immediate ack
      run_program(1'b1);                             // Random wait states
      compare_store_runs();
      finish_run();
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      errors++;
      $display("Timeout: the core stopped after %0d of %0d expected bus accesses",
               acc_idx, exp_cnt);
      finish_run();
   end

endmodule

`default_nettype wire

// File: tests/wb_oisc_assert.sv
`timescale 1ns/10ps
`default_nettype none

module wb_oisc_assert (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  stb_i,
   input  wire                  cyc_i,
   input  wire                  we_i,
   input  wire                  ack_i,
   input  wire oisc_pkg::word_t adr_i
);
   import oisc_pkg::*;

   int unsigned fail_cnt = 0;                        // Failed assertions so far

   // -------------------------------------------------------------------------
   // Wishbone master rules
   stb_cyc_equal: assert property (@(posedge clk) disable iff (!rst_n)
      stb_i == cyc_i)
      else begin
         fail_cnt++;
         $error("stb and cyc differ");
      end

   // Request held until the slave answers
   adr_held: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(stb_i) && !$past(ack_i)) |-> (stb_i && adr_i == $past(adr_i)))
      else begin
         fail_cnt++;
         $error("stb dropped or address changed before ack");
      end

   // -------------------------------------------------------------------------
   // Reset values
   reset_idle: assert property (@(posedge clk)
      !rst_n |-> (!stb_i && !cyc_i && !we_i))
      else begin
         fail_cnt++;
         $error("bus active while reset is asserted");
      end

endmodule

`default_nettype wire
